/* Makefile */
# Verilator build and run for the commit stage testbench.

SIM       := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := commit_unit_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := SIMULATION PASSED
FAIL_MSG  := SIMULATION FAILED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run judged as failing, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/commit_buffer.sv */
/*
  Age-ordered commit buffer, index 0 is the oldest entry.
  Completions match by pc against waiting entries only; on a tie the
  higher-numbered port wins. A pair that does not fit is dropped whole,
  so decode is expected to honour full.
*/
`timescale 1ns/1ps

module commit_buffer
    import commit_cfg_pkg::*;
    import commit_types_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic [1:0]   pair_valid,
    input  pc_t          pair_pc0,
    input  pc_t          pair_pc1,
    input  pc_t          complete0_pc,
    input  pc_t          complete1_pc,
    input  pc_t          complete2_pc,
    input  reg_addr_t    complete0_addr,
    input  reg_addr_t    complete1_addr,
    input  reg_addr_t    complete2_addr,
    input  data_t        complete0_data,
    input  data_t        complete1_data,
    input  data_t        complete2_data,
    input  logic         complete0_ena,
    input  logic         complete1_ena,
    input  logic         complete2_ena,
    input  logic         head_pop,
    output entry_state_e head_state,
    output pc_t          head_pc,
    output logic         head_ena,
    output reg_addr_t    head_addr,
    output data_t        head_data,
    output logic         full
);

    localparam int CPL_PORTS = 3;

    entry_state_e         entry_state [BUF_DEPTH];
    pc_t                  entry_pc    [BUF_DEPTH];
    logic                 entry_ena   [BUF_DEPTH];
    reg_addr_t            entry_addr  [BUF_DEPTH];
    data_t                entry_data  [BUF_DEPTH];
    logic [BUF_IDX_W-1:0] occupancy;

    pc_t       cpl_pc   [CPL_PORTS];
    reg_addr_t cpl_addr [CPL_PORTS];
    data_t     cpl_data [CPL_PORTS];
    logic      cpl_ena  [CPL_PORTS];

    entry_state_e cmp_state [BUF_DEPTH];  // entries after completion.
    logic         cmp_ena   [BUF_DEPTH];
    reg_addr_t    cmp_addr  [BUF_DEPTH];
    data_t        cmp_data  [BUF_DEPTH];

    entry_state_e         nxt_state [BUF_DEPTH];
    pc_t                  nxt_pc    [BUF_DEPTH];
    logic                 nxt_ena   [BUF_DEPTH];
    reg_addr_t            nxt_addr  [BUF_DEPTH];
    data_t                nxt_data  [BUF_DEPTH];
    logic [BUF_IDX_W-1:0] nxt_occupancy;
    logic [BUF_IDX_W-1:0] remain;
    logic [BUF_IDX_W-1:0] lane_cnt;
    logic                 take;

    assign cpl_pc[0]   = complete0_pc;
    assign cpl_pc[1]   = complete1_pc;
    assign cpl_pc[2]   = complete2_pc;
    assign cpl_addr[0] = complete0_addr;
    assign cpl_addr[1] = complete1_addr;
    assign cpl_addr[2] = complete2_addr;
    assign cpl_data[0] = complete0_data;
    assign cpl_data[1] = complete1_data;
    assign cpl_data[2] = complete2_data;
    assign cpl_ena[0]  = complete0_ena;
    assign cpl_ena[1]  = complete1_ena;
    assign cpl_ena[2]  = complete2_ena;

    // later ports overwrite earlier ones, so port 2 has priority.
    always_comb begin
        for (int i = 0; i < BUF_DEPTH; i++) begin
            cmp_state[i] = entry_state[i];
            cmp_ena[i]   = entry_ena[i];
            cmp_addr[i]  = entry_addr[i];
            cmp_data[i]  = entry_data[i];
            for (int p = 0; p < CPL_PORTS; p++) begin
                if (entry_state[i] == entry_waiting && entry_pc[i] == cpl_pc[p]) begin
                    cmp_state[i] = entry_done;
                    cmp_ena[i]   = cpl_ena[p];
                    cmp_addr[i]  = cpl_addr[p];
                    cmp_data[i]  = cpl_data[p];
                end
            end
        end
    end

    always_comb begin
        lane_cnt = BUF_IDX_W'(pair_valid[0]) + BUF_IDX_W'(pair_valid[1]);
        remain   = occupancy - BUF_IDX_W'(head_pop);
        take     = (remain + lane_cnt) <= BUF_IDX_W'(BUF_DEPTH);
        for (int i = 0; i < BUF_DEPTH - 1; i++) begin
            nxt_state[i] = head_pop ? cmp_state[i+1] : cmp_state[i];
            nxt_pc[i]    = head_pop ? entry_pc[i+1]  : entry_pc[i];
            nxt_ena[i]   = head_pop ? cmp_ena[i+1]   : cmp_ena[i];
            nxt_addr[i]  = head_pop ? cmp_addr[i+1]  : cmp_addr[i];
            nxt_data[i]  = head_pop ? cmp_data[i+1]  : cmp_data[i];
        end
        nxt_state[BUF_DEPTH-1] = head_pop ? entry_empty : cmp_state[BUF_DEPTH-1];
        nxt_pc[BUF_DEPTH-1]    = entry_pc[BUF_DEPTH-1];
        nxt_ena[BUF_DEPTH-1]   = cmp_ena[BUF_DEPTH-1];
        nxt_addr[BUF_DEPTH-1]  = cmp_addr[BUF_DEPTH-1];
        nxt_data[BUF_DEPTH-1]  = cmp_data[BUF_DEPTH-1];
        // new lanes land right behind the surviving entries.
        for (int i = 0; i < BUF_DEPTH; i++) begin
            if (take && pair_valid[0] && BUF_IDX_W'(i) == remain) begin
                nxt_state[i] = entry_waiting;
                nxt_pc[i]    = pair_pc0;
            end
            if (take && pair_valid[1] && BUF_IDX_W'(i) == remain + 1'b1) begin
                nxt_state[i] = entry_waiting;
                nxt_pc[i]    = pair_pc1;
            end
        end
        nxt_occupancy = take ? remain + lane_cnt : remain;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy <= '0;
            for (int i = 0; i < BUF_DEPTH; i++) begin
                entry_state[i] <= entry_empty;
            end
        end else begin
            occupancy <= nxt_occupancy;
            for (int i = 0; i < BUF_DEPTH; i++) begin
                entry_state[i] <= nxt_state[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < BUF_DEPTH; i++) begin
            entry_pc[i]   <= nxt_pc[i];
            entry_ena[i]  <= nxt_ena[i];
            entry_addr[i] <= nxt_addr[i];
            entry_data[i] <= nxt_data[i];
        end
    end

    assign head_state = entry_state[0];
    assign head_pc    = entry_pc[0];
    assign head_ena   = entry_ena[0];
    assign head_addr  = entry_addr[0];
    assign head_data  = entry_data[0];
    assign full       = occupancy >= BUF_IDX_W'(FULL_MARK);

endmodule

/* hw/commit_cfg_pkg.sv */
/*
  Sizes and widths of the commit stage.
  BUF_IDX_W must hold the count BUF_DEPTH itself, not only an index.
  FULL_MARK leaves room for the pair held in dispatch ordering plus
  one more pair arriving behind it.
*/
package commit_cfg_pkg;

    localparam int XLEN         = 64;  // pc and data width.
    localparam int REG_ADDR_W   = 5;   // riscv integer register index.

    localparam int BUF_DEPTH    = 8;
    localparam int BUF_IDX_W    = 4;   // counts 0 to 8.

    localparam int DECODE_CNT_W = 3;

    // raised at this occupancy so decode stops before the buffer overflows.
    localparam int FULL_MARK    = 4;

endpackage

/* hw/commit_types_pkg.sv */
/*
  Value types of the commit stage and the buffer entry state.
  A pc of zero never names a real instruction and is used as "none".
*/
package commit_types_pkg;

    import commit_cfg_pkg::*;

    typedef logic [XLEN-1:0]         pc_t;
    typedef logic [XLEN-1:0]         data_t;
    typedef logic [REG_ADDR_W-1:0]   reg_addr_t;
    typedef logic [DECODE_CNT_W-1:0] decode_cnt_t;

    // life of one commit buffer entry.
    typedef enum logic [1:0] {
        entry_empty   = 2'd0,
        entry_waiting = 2'd1,  // dispatched, no result yet.
        entry_done    = 2'd2   // result captured.
    } entry_state_e;

endpackage

/* hw/commit_unit.sv */
/*
  Commit stage top: dispatch ordering, commit buffer and retirement in a chain.
  Decode must present no enabled slot while full is high.
  Writeback has no back-pressure.
*/
`timescale 1ns/1ps

module commit_unit
    import commit_types_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  decode_cnt_t decode0_counter,
    input  logic        decode0_clean,
    input  pc_t         decode0_pc,
    input  decode_cnt_t decode1_counter,
    input  logic        decode1_clean,
    input  pc_t         decode1_pc,
    input  pc_t         complete0_pc,
    input  reg_addr_t   complete0_addr,
    input  data_t       complete0_data,
    input  logic        complete0_ena,
    input  pc_t         complete1_pc,
    input  reg_addr_t   complete1_addr,
    input  data_t       complete1_data,
    input  logic        complete1_ena,
    input  pc_t         complete2_pc,
    input  reg_addr_t   complete2_addr,
    input  data_t       complete2_data,
    input  logic        complete2_ena,
    output logic        wb_valid,
    output logic        wb_ena,
    output reg_addr_t   wb_addr,
    output data_t       wb_data,
    output pc_t         wb_pc,
    output logic        full
);

    logic [1:0]   pair_valid;
    pc_t          pair_pc0;
    pc_t          pair_pc1;
    entry_state_e head_state;
    pc_t          head_pc;
    logic         head_ena;
    reg_addr_t    head_addr;
    data_t        head_data;
    logic         head_pop;

    dispatch_order u_dispatch_order (
        .clk(clk), .reset(reset),
        .decode0_counter(decode0_counter), .decode1_counter(decode1_counter),
        .decode0_clean(decode0_clean), .decode1_clean(decode1_clean),
        .decode0_pc(decode0_pc), .decode1_pc(decode1_pc),
        .pair_valid(pair_valid), .pair_pc0(pair_pc0), .pair_pc1(pair_pc1)
    );

    commit_buffer u_commit_buffer (
        .clk(clk), .reset(reset),
        .pair_valid(pair_valid), .pair_pc0(pair_pc0), .pair_pc1(pair_pc1),
        .complete0_pc(complete0_pc), .complete1_pc(complete1_pc),
        .complete2_pc(complete2_pc),
        .complete0_addr(complete0_addr), .complete1_addr(complete1_addr),
        .complete2_addr(complete2_addr),
        .complete0_data(complete0_data), .complete1_data(complete1_data),
        .complete2_data(complete2_data),
        .complete0_ena(complete0_ena), .complete1_ena(complete1_ena),
        .complete2_ena(complete2_ena),
        .head_pop(head_pop),
        .head_state(head_state), .head_pc(head_pc), .head_ena(head_ena),
        .head_addr(head_addr), .head_data(head_data),
        .full(full)
    );

    retire_select u_retire_select (
        .clk(clk), .reset(reset),
        .head_state(head_state), .head_pc(head_pc), .head_ena(head_ena),
        .head_addr(head_addr), .head_data(head_data),
        .head_pop(head_pop),
        .wb_valid(wb_valid), .wb_ena(wb_ena), .wb_addr(wb_addr),
        .wb_data(wb_data), .wb_pc(wb_pc)
    );

endmodule

/* hw/dispatch_order.sv */
/*
  Filters the two decode slots and registers them in ascending pc order.
  Lane 0 always carries the older instruction; lane 1 is only valid with lane 0.
  Two enabled slots with the same pc are both dropped.
*/
`timescale 1ns/1ps

module dispatch_order
    import commit_cfg_pkg::*;
    import commit_types_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [DECODE_CNT_W-1:0] decode0_counter,
    input  logic [DECODE_CNT_W-1:0] decode1_counter,
    input  logic                    decode0_clean,
    input  logic                    decode1_clean,
    input  pc_t                     decode0_pc,
    input  pc_t                     decode1_pc,
    output logic [1:0]              pair_valid,
    output pc_t                     pair_pc0,
    output pc_t                     pair_pc1
);

    logic slot0_en;
    logic slot1_en;
    logic first_valid;
    logic second_valid;
    pc_t  first_pc;
    pc_t  second_pc;

    assign slot0_en = (|decode0_counter) && !decode0_clean && (decode0_pc != '0);
    assign slot1_en = (|decode1_counter) && !decode1_clean && (decode1_pc != '0);

    always_comb begin
        first_valid  = 1'b0;
        second_valid = 1'b0;
        first_pc     = decode0_pc;
        second_pc    = decode1_pc;
        if (slot0_en && slot1_en) begin
            if (decode0_pc != decode1_pc) begin
                first_valid  = 1'b1;
                second_valid = 1'b1;
                if (decode1_pc < decode0_pc) begin  // slot 1 is older.
                    first_pc  = decode1_pc;
                    second_pc = decode0_pc;
                end
            end
        end else if (slot0_en) begin
            first_valid = 1'b1;
        end else if (slot1_en) begin
            first_valid = 1'b1;
            first_pc    = decode1_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pair_valid <= 2'b00;
        end else begin
            pair_valid <= {second_valid, first_valid};
        end
    end

    always_ff @(posedge clk) begin
        pair_pc0 <= first_pc;
        pair_pc1 <= second_pc;
    end

endmodule

/* hw/retire_select.sv */
/*
  Retires the head entry once its result is in, at most one per cycle.
  head_pop is combinational from the head state; the writeback is
  registered and appears one cycle later as a single-cycle pulse.
*/
`timescale 1ns/1ps

module retire_select
    import commit_cfg_pkg::*;
    import commit_types_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  entry_state_e head_state,
    input  pc_t          head_pc,
    input  logic         head_ena,
    input  reg_addr_t    head_addr,
    input  data_t        head_data,
    output logic         head_pop,
    output logic         wb_valid,
    output logic         wb_ena,
    output reg_addr_t    wb_addr,
    output data_t        wb_data,
    output pc_t          wb_pc
);

    logic      cap_ena;
    reg_addr_t cap_addr;
    data_t     cap_data;

    assign head_pop = (head_state == entry_done);  // strictly in order.

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= head_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (head_pop) begin
            cap_ena  <= head_ena;
            cap_addr <= head_addr;
            cap_data <= head_data;
            wb_pc    <= head_pc;
        end
    end

    assign wb_ena  = wb_valid & cap_ena;
    assign wb_addr = wb_valid ? cap_addr : '0;
    assign wb_data = wb_valid ? cap_data : '0;

endmodule

/* project.f */
hw/commit_cfg_pkg.sv
hw/commit_types_pkg.sv
hw/dispatch_order.sv
hw/commit_buffer.sv
hw/retire_select.sv
hw/commit_unit.sv
test/tb_clock.sv
test/commit_unit_props.sv
test/commit_unit_tb.sv

/* test/commit_unit_props.sv */
/*
  Concurrent checks on the commit buffer, attached with bind.
  Only occupancy, full, the entry at the full mark and the head pop
  strobe are observed.
*/
`timescale 1ns/1ps

module commit_unit_props
    import commit_cfg_pkg::*;
    import commit_types_pkg::*;
(
    input logic                 clk,
    input logic                 reset,
    input logic [BUF_IDX_W-1:0] occupancy,
    input logic                 full,
    input entry_state_e         mark_state,  // entry FULL_MARK-1.
    input logic                 head_pop,
    input entry_state_e         head_state
);

    // entries fill from index 0, so this one in use means FULL_MARK are held.
    full_at_mark: assert property (
        @(posedge clk) disable iff (reset)
        (mark_state != entry_empty) |-> full
    ) else $error("full is low while %0d entries are held", occupancy);

    pop_when_done: assert property (
        @(posedge clk) disable iff (reset)
        head_pop |-> (head_state == entry_done)
    ) else $error("head popped before its result arrived");

    occupancy_bound: assert property (
        @(posedge clk) disable iff (reset)
        occupancy <= BUF_IDX_W'(BUF_DEPTH)
    ) else $error("occupancy %0d is beyond the buffer depth", occupancy);

endmodule

bind commit_buffer commit_unit_props props0 (
    .clk(clk), .reset(reset), .occupancy(occupancy), .full(full),
    .mark_state(entry_state[FULL_MARK-1]),
    .head_pop(head_pop), .head_state(head_state)
);

/* test/commit_unit_tb.sv */
/*
  Testbench for the commit stage: random pc pairs from a fixed seed,
  a queue model of dispatch order and a result table keyed by pc.
  Generated pcs are unique, so a completion never hits two entries.
*/
`timescale 1ns/1ps

module commit_unit_tb
    import commit_cfg_pkg::*;
    import commit_types_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        reset;
    decode_cnt_t dec_cnt   [2];
    logic        dec_clean [2];
    pc_t         dec_pc    [2];
    pc_t         c_pc      [3];
    reg_addr_t   c_addr    [3];
    data_t       c_data    [3];
    logic        c_ena     [3];
    logic        wb_valid;
    logic        wb_ena;
    reg_addr_t   wb_addr;
    data_t       wb_data;
    pc_t         wb_pc;
    logic        full;

    pc_t       exp_pc   [$];
    logic      exp_ena  [pc_t];
    reg_addr_t exp_addr [pc_t];
    data_t     exp_data [pc_t];
    pc_t       pending  [$];  // dispatched, not yet completed.
    pc_t       ignored  [$];
    pc_t       got_pc   [$];
    logic      got_ena  [$];
    reg_addr_t got_addr [$];
    data_t     got_data [$];

    integer seed;
    pc_t    next_pc;
    int     errors;
    int     errs_at_start;
    int     tests_run;
    int     tests_failed;
    bit     run_closed;

    tb_clock #(.PERIOD_NS(40)) clk_gen (.clk(clk));

    commit_unit dut0 (
        .clk(clk), .reset(reset),
        .decode0_counter(dec_cnt[0]), .decode0_clean(dec_clean[0]), .decode0_pc(dec_pc[0]),
        .decode1_counter(dec_cnt[1]), .decode1_clean(dec_clean[1]), .decode1_pc(dec_pc[1]),
        .complete0_pc(c_pc[0]), .complete0_addr(c_addr[0]),
        .complete0_data(c_data[0]), .complete0_ena(c_ena[0]),
        .complete1_pc(c_pc[1]), .complete1_addr(c_addr[1]),
        .complete1_data(c_data[1]), .complete1_ena(c_ena[1]),
        .complete2_pc(c_pc[2]), .complete2_addr(c_addr[2]),
        .complete2_data(c_data[2]), .complete2_ena(c_ena[2]),
        .wb_valid(wb_valid), .wb_ena(wb_ena), .wb_addr(wb_addr),
        .wb_data(wb_data), .wb_pc(wb_pc), .full(full)
    );

    always @(negedge clk) begin  // mid-cycle, outputs are settled.
        if (!reset && wb_valid) begin
            got_pc.push_back(wb_pc);
            got_ena.push_back(wb_ena);
            got_addr.push_back(wb_addr);
            got_data.push_back(wb_data);
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic decode_cnt_t rand_count();
        return decode_cnt_t'(1 + rand_below(7));
    endfunction

    function automatic pc_t fresh_pc();
        next_pc = next_pc + pc_t'(4 + 4 * rand_below(4));
        return next_pc;
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
        $display("SIMULATION FAILED");
        run_closed = 1'b1;
        $finish;
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s %s: expected %h actual %h", test, field, expected, actual);
            errors++;
        end
    endtask

    task automatic idle_decode();
        for (int s = 0; s < 2; s++) begin
            dec_cnt[s]   = '0;
            dec_clean[s] = 1'b0;
            dec_pc[s]    = '0;
        end
    endtask

    task automatic clear_ports();
        for (int p = 0; p < 3; p++) begin
            c_pc[p]   = '0;  // no entry ever holds pc zero.
            c_addr[p] = '0;
            c_data[p] = '0;
            c_ena[p]  = 1'b0;
        end
    endtask

    task automatic keep(input pc_t pc);
        exp_pc.push_back(pc);
        pending.push_back(pc);
    endtask

    task automatic wait_not_full();
        int waited;
        waited = 0;
        while (full && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        if (full) begin
            report_timeout("full to fall");
        end
    endtask

    task automatic dispatch(input decode_cnt_t cnt0, input logic clean0, input pc_t pc0,
                            input decode_cnt_t cnt1, input logic clean1, input pc_t pc1);
        logic en0;
        logic en1;
        en0 = (cnt0 != '0) && !clean0 && (pc0 != '0);
        en1 = (cnt1 != '0) && !clean1 && (pc1 != '0);
        if (en0 && en1 && pc0 == pc1) begin
            // twin pcs, both dropped.
        end else if (en0 && en1) begin
            keep(pc0 < pc1 ? pc0 : pc1);
            keep(pc0 < pc1 ? pc1 : pc0);
        end else if (en0) begin
            keep(pc0);
        end else if (en1) begin
            keep(pc1);
        end
        wait_not_full();
        dec_cnt[0]   = cnt0;
        dec_clean[0] = clean0;
        dec_pc[0]    = pc0;
        dec_cnt[1]   = cnt1;
        dec_clean[1] = clean1;
        dec_pc[1]    = pc1;
        step();
        idle_decode();
    endtask

    task automatic dispatch_random_pair();
        pc_t lo;
        pc_t hi;
        lo = fresh_pc();
        hi = fresh_pc();
        if (rand_below(2) == 1) begin
            dispatch(rand_count(), 1'b0, hi, rand_count(), 1'b0, lo);
        end else begin
            dispatch(rand_count(), 1'b0, lo, rand_count(), 1'b0, hi);
        end
    endtask

    task automatic drive_port(input int port, input pc_t pc);
        c_pc[port]   = pc;
        c_addr[port] = reg_addr_t'($random(seed));
        c_data[port] = {$random(seed), $random(seed)};
        c_ena[port]  = 1'($random(seed));
    endtask

    task automatic record_port(input int port);
        exp_ena[c_pc[port]]  = c_ena[port];
        exp_addr[c_pc[port]] = c_addr[port];
        exp_data[c_pc[port]] = c_data[port];
    endtask

    task automatic complete_on(input pc_t pc, input int port);
        drive_port(port, pc);
        record_port(port);
        step();
        clear_ports();
    endtask

    task automatic complete_dup(input pc_t pc);
        int lo;
        int hi;
        lo = rand_below(2);
        hi = lo + 1 + rand_below(2 - lo);
        drive_port(lo, pc);
        drive_port(hi, pc);
        record_port(hi);  // higher port wins.
        step();
        clear_ports();
    endtask

    task automatic complete_pending(input bit with_dup);
        int  idx;
        pc_t pc;
        while (pending.size() > 0) begin
            idx = rand_below(pending.size());
            pc  = pending[idx];
            pending.delete(idx);
            if (with_dup && rand_below(2) == 1) begin
                complete_dup(pc);
            end else begin
                complete_on(pc, rand_below(3));
            end
        end
    endtask

    task automatic test_start();
        errs_at_start = errors;
    endtask

    task automatic drain_check(input string name);
        int  waited;
        pc_t pc;
        waited = 0;
        while (got_pc.size() < exp_pc.size() && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        if (got_pc.size() < exp_pc.size()) begin
            report_timeout({"writebacks of test ", name});
        end
        repeat (4) step();  // room for any stray writeback.
        check_value(name, "writeback count", 64'(exp_pc.size()), 64'(got_pc.size()));
        for (int i = 0; i < exp_pc.size() && i < got_pc.size(); i++) begin
            pc = exp_pc[i];
            check_value(name, "wb_pc", pc, got_pc[i]);
            check_value(name, "wb_ena", 64'(exp_ena[pc]), 64'(got_ena[i]));
            check_value(name, "wb_addr", 64'(exp_addr[pc]), 64'(got_addr[i]));
            check_value(name, "wb_data", exp_data[pc], got_data[i]);
        end
        tests_run++;
        if (errors == errs_at_start) begin
            $display("test %s: ok, %0d writebacks", name, got_pc.size());
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errors - errs_at_start);
        end
        exp_pc.delete();
        exp_ena.delete();
        exp_addr.delete();
        exp_data.delete();
        got_pc.delete();
        got_ena.delete();
        got_addr.delete();
        got_data.delete();
    endtask

    initial begin
        pc_t pa;
        pc_t pb;
        seed         = 28;
        next_pc      = 64'h8000_0000;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        run_closed   = 1'b0;
        reset        = 1'b1;
        idle_decode();
        clear_ports();
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        test_start();
        check_value("reset", "wb_valid", 64'd0, 64'(wb_valid));
        check_value("reset", "full", 64'd0, 64'(full));
        repeat (10) step();
        drain_check("reset");

        test_start();
        repeat (5) begin
            dispatch_random_pair();
            dispatch_random_pair();
            step();  // last pair reaches the buffer.
            complete_pending(1'b0);
        end
        drain_check("ordering");

        test_start();
        pa = fresh_pc();
        pb = fresh_pc();
        dispatch('0, 1'b0, pa, rand_count(), 1'b0, pb);
        ignored.push_back(pa);
        pa = fresh_pc();
        pb = fresh_pc();
        dispatch(rand_count(), 1'b0, pa, rand_count(), 1'b1, pb);
        ignored.push_back(pb);
        pb = fresh_pc();
        dispatch(rand_count(), 1'b0, '0, rand_count(), 1'b0, pb);
        pa = fresh_pc();
        dispatch(rand_count(), 1'b0, pa, rand_count(), 1'b0, pa);
        ignored.push_back(pa);
        step();
        complete_pending(1'b0);
        while (ignored.size() > 0) begin
            complete_on(ignored.pop_front(), rand_below(3));
        end
        drain_check("filtering");

        test_start();
        repeat (4) begin
            dispatch_random_pair();
            step();
            complete_pending(1'b1);
        end
        drain_check("completion data");

        test_start();
        repeat (3) dispatch_random_pair();
        step();
        check_value("full", "full", 64'd1, 64'(full));
        while (pending.size() > 1) begin
            complete_on(pending.pop_back(), rand_below(3));  // youngest first.
        end
        repeat (3) step();
        check_value("full", "early writebacks", 64'd0, 64'(got_pc.size()));
        complete_on(pending.pop_front(), rand_below(3));
        dispatch_random_pair();  // stalls until full falls.
        step();
        complete_pending(1'b0);
        drain_check("full");

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        run_closed = 1'b1;
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // run stopped early, e.g. by a bound assertion.
    final begin
        if (!run_closed) begin
            $display("SIMULATION FAILED");
        end
    end

endmodule

/* test/tb_clock.sv */
/*
  Free-running testbench clock, starts low.
  PERIOD_NS should be even so both phases are whole nanoseconds.
*/
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule
